// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module motion_tb \
  -f verilog.f --Mdir obj_dir -o motion_sim

./obj_dir/motion_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
  echo "Run reported failure, see sim.log"
  exit 1
fi

// ==== src/cmd_decoder.sv ====
`timescale 1ns/1ps
`include "stepper_consts.svh"

module cmd_decoder import stepper_pkg::*; (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        word_valid,
  output logic        word_ready,
  input  logic [63:0] word_data,
  output logic        move_valid,
  input  logic        move_ready,
  output move_t       move_data,
  output logic        rep_valid,
  input  logic        rep_ready,
  output logic [63:0] rep_data,
  output logic        enable,
  output logic [7:0]  clk_divisor
);

  localparam logic [63:0] VERSION_WORD = {
    40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH
  };

  dec_state_t state;
  move_t      move_r;       // Move under assembly
  logic       rep_valid_r;
  logic       word_fire;
  logic [7:0] header;

  // Host stalls while a move or a reply waits to be taken
  assign word_ready = (state != PUSH) && !rep_valid_r;
  assign word_fire  = word_valid & word_ready;
  assign header     = word_data[63:56];

  assign move_valid = (state == PUSH);
  assign move_data  = move_r;
  assign rep_valid  = rep_valid_r;
  assign rep_data   = VERSION_WORD;  // Only reply we produce

  // Move body words, no reset needed on payload
  always_ff @(posedge CLK) begin
    if (word_fire) begin
      case (state)
        HEADER: begin
          if (header == `CMD_COORDINATED_STEP) move_r.dir <= word_data[0];
        end
        DURATION:  move_r.duration  <= word_data;
        INCREMENT: move_r.increment <= word_data;
        INCINC:    move_r.incinc    <= word_data;
        default:   ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state       <= HEADER;
      enable      <= 1'b0;
      clk_divisor <= `DEFAULT_CLK_DIVISOR;
      rep_valid_r <= 1'b0;
    end else begin
      if (rep_valid_r && rep_ready) rep_valid_r <= 1'b0;

      case (state)
        HEADER: begin
          if (word_fire) begin
            case (header)
              `CMD_COORDINATED_STEP: state <= DURATION;
              `CMD_MOTOR_ENABLE:     enable <= word_data[0];
              `CMD_CLK_DIVISOR:      clk_divisor <= word_data[7:0];
              `CMD_API_VERSION:      rep_valid_r <= 1'b1;
              default:               ;  // Unknown header dropped
            endcase
          end
        end
        DURATION: begin
          if (word_fire) state <= INCREMENT;
        end
        INCREMENT: begin
          if (word_fire) state <= INCINC;
        end
        INCINC: begin
          if (word_fire) state <= PUSH;
        end
        PUSH: begin
          // Full buffer holds us here
          if (move_ready) state <= HEADER;
        end
        default: state <= HEADER;
      endcase
    end
  end

endmodule

// ==== src/dda_stepper.sv ====
`timescale 1ns/1ps
`include "stepper_consts.svh"

module dda_stepper import stepper_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  halt_n,
  input  logic  enable,
  input  logic  mv_valid,
  output logic  mv_ready,
  input  move_t mv_data,
  output logic  run_tick,
  input  logic  tick,
  output logic  step,
  output logic  dir,
  output logic  busy,
  output logic  move_done
);

  localparam logic signed [63:0] THRESHOLD = `STEP_THRESHOLD;

  logic        [63:0] remaining;  // Ticks left in this move
  logic signed [63:0] inc_r;
  logic signed [63:0] incinc_r;
  logic signed [63:0] accum;      // Substep accumulator
  logic signed [63:0] acc_sum;
  logic               load;

  // Idle, motor on and not halted
  assign mv_ready = !busy && enable && halt_n;
  assign load     = mv_valid & mv_ready;
  assign run_tick = busy;
  assign acc_sum  = accum + inc_r;

  // Per-move payload
  always_ff @(posedge CLK) begin
    if (load) begin
      remaining <= mv_data.duration;
      inc_r     <= mv_data.increment;
      incinc_r  <= mv_data.incinc;
    end else if (busy && tick && halt_n) begin
      remaining <= remaining - 64'd1;
      inc_r     <= inc_r + incinc_r;  // Acceleration term
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      step      <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
      accum     <= '0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (!halt_n) begin
        // Abandon the move, accumulator left as is
        busy <= 1'b0;
      end else if (load) begin
        busy <= 1'b1;
        dir  <= mv_data.dir;
      end else if (busy && tick) begin
        if (acc_sum > THRESHOLD) begin
          accum <= acc_sum - THRESHOLD;
          step  <= 1'b1;
        end else begin
          accum <= acc_sum;
        end
        if (remaining == 64'd1) begin
          busy      <= 1'b0;
          move_done <= 1'b1;  // Last tick of the move
        end
      end
    end
  end

endmodule

// ==== src/motion_top.sv ====
`timescale 1ns/1ps
`include "stepper_consts.svh"

module motion_top import stepper_pkg::*; (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        word_valid,
  output logic        word_ready,
  input  logic [63:0] word_data,
  output logic        reply_valid,
  input  logic        reply_ready,
  output logic [63:0] reply_data,
  input  logic        halt_n,
  output logic        step,
  output logic        dir,
  output logic        enable,
  output logic        busy,
  output logic        move_done,
  output logic        buffer_ready
);

  // Decoder to move buffer
  logic        move_valid;
  logic        move_ready;
  move_t       move_data;
  // Move buffer to stepper
  logic        mv_valid;
  logic        mv_ready;
  move_t       mv_data;
  // Decoder to reply buffer
  logic        rep_valid;
  logic        rep_ready;
  logic [63:0] rep_data;

  logic [7:0]  clk_divisor;
  logic        run_tick;
  logic        tick;
  logic        move_flush;

  assign move_flush   = ~halt_n;  // Halt drops all queued moves
  assign buffer_ready = move_ready;

  cmd_decoder i_cmd_decoder (
    .CLK(CLK), .resetn(resetn),
    .word_valid(word_valid), .word_ready(word_ready), .word_data(word_data),
    .move_valid(move_valid), .move_ready(move_ready), .move_data(move_data),
    .rep_valid(rep_valid), .rep_ready(rep_ready), .rep_data(rep_data),
    .enable(enable), .clk_divisor(clk_divisor)
  );

  sync_fifo #(.payload_t(move_t), .DEPTH(`MOVE_BUFFER_DEPTH)) i_move_fifo (
    .CLK(CLK), .resetn(resetn), .flush(move_flush),
    .in_valid(move_valid), .in_ready(move_ready), .in_data(move_data),
    .out_valid(mv_valid), .out_ready(mv_ready), .out_data(mv_data)
  );

  sync_fifo #(.payload_t(logic [63:0]), .DEPTH(`REPLY_BUFFER_DEPTH)) i_reply_fifo (
    .CLK(CLK), .resetn(resetn), .flush(1'b0),
    .in_valid(rep_valid), .in_ready(rep_ready), .in_data(rep_data),
    .out_valid(reply_valid), .out_ready(reply_ready), .out_data(reply_data)
  );

  tick_divider i_tick_divider (
    .CLK(CLK), .resetn(resetn), .run(run_tick), .divisor(clk_divisor), .tick(tick)
  );

  dda_stepper i_dda_stepper (
    .CLK(CLK), .resetn(resetn), .halt_n(halt_n), .enable(enable),
    .mv_valid(mv_valid), .mv_ready(mv_ready), .mv_data(mv_data),
    .run_tick(run_tick), .tick(tick),
    .step(step), .dir(dir), .busy(busy), .move_done(move_done)
  );

endmodule

// ==== src/stepper_consts.svh ====
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

// Command header codes, top byte of a word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE     8'h0a
`define CMD_CLK_DIVISOR      8'h0b
`define CMD_API_VERSION      8'hfe

// Reply to the version query
`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd0

`define MOVE_BUFFER_DEPTH  4
`define REPLY_BUFFER_DEPTH 2

// One full step in substep units (2^32)
`define STEP_THRESHOLD 64'sh0000_0001_0000_0000

`define DEFAULT_CLK_DIVISOR 8'd3

`endif

// ==== src/stepper_pkg.sv ====
package stepper_pkg;

  // One buffered coordinated move, 193 bits
  typedef struct packed {
    logic               dir;        // Header bit 0
    logic        [63:0] duration;   // Ticks, never zero
    logic signed [63:0] increment;  // Substeps added per tick
    logic signed [63:0] incinc;     // Added to increment per tick
  } move_t;

  // Command decoder states
  // HEADER waits for a command word,
  // the next three collect the move body
  typedef enum logic [2:0] {
    HEADER,
    DURATION,
    INCREMENT,
    INCINC,
    PUSH       // Offer the move to the buffer
  } dec_state_t;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [63:0],
  parameter int  DEPTH     = 4
) (
  input  logic     CLK,
  input  logic     resetn,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic     [CNT_W-1:0] count_next;
  logic                 wr_en;
  logic                 rd_en;

  assign wr_en = in_valid & in_ready;
  assign rd_en = out_valid & out_ready;

  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;  // Both or neither
    endcase
  end

  // Head entry straight from storage
  assign out_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (wr_en) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge CLK) begin
    if (!resetn || flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
      in_ready  <= 1'b1;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count     <= count_next;
      out_valid <= (count_next != '0);
      in_ready  <= (count_next != CNT_W'(DEPTH));  // Room left
    end
  end

endmodule

// ==== src/tick_divider.sv ====
`timescale 1ns/1ps

module tick_divider (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       run,
  input  logic [7:0] divisor,
  output logic       tick
);

  logic [7:0] count;  // Cycles left before the next tick

  // Tick on the last cycle of each period
  assign tick = run & (count == 8'd0);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= 8'd0;
    end else if (!run || tick) begin
      // Reload so a period is divisor+1 cycles
      count <= divisor;
    end else begin
      count <= count - 8'd1;
    end
  end

endmodule

// ==== verif/motion_props.sv ====
`timescale 1ns/1ps

module motion_props (
  input logic        CLK,
  input logic        resetn,
  input logic        halt_n,
  input logic        step,
  input logic        move_done,
  input logic        busy,
  input logic        enable,
  input logic        word_ready,
  input logic        buffer_ready,
  input logic        reply_valid,
  input logic        reply_ready,
  input logic [63:0] reply_data,
  input logic [7:0]  clk_divisor
);

  int fail_count;  // Assertion failures so far

  // Idle outputs one edge into reset
  a_reset_state: assert property (@(posedge CLK)
    !resetn |=> (!step && !move_done && !busy && !reply_valid && !enable
                 && word_ready && buffer_ready))
    else begin
      fail_count++;
      $error("outputs not idle after a reset edge");
    end

  // A stalled reply must not change
  a_reply_hold: assert property (@(posedge CLK) disable iff (!resetn)
    (reply_valid && !reply_ready) |=> (reply_valid && $stable(reply_data)))
    else begin
      fail_count++;
      $error("reply changed or vanished while stalled");
    end

  a_step_single: assert property (@(posedge CLK) disable iff (!resetn)
    (step && clk_divisor != 8'd0) |=> !step)
    else begin
      fail_count++;
      $error("step high for two cycles in a row");
    end

  // Halt drops the move without completion
  a_halt_drop: assert property (@(posedge CLK) disable iff (!resetn)
    !halt_n |=> (!busy && !move_done))
    else begin
      fail_count++;
      $error("busy or move_done after halt");
    end

  a_done_after_busy: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |-> ($past(busy) && !busy))
    else begin
      fail_count++;
      $error("move_done without a finished move");
    end

endmodule

// ==== verif/motion_tb.sv ====
`timescale 1ns/1ps
`include "stepper_consts.svh"

module motion_tb import stepper_pkg::*; ();

  localparam logic signed [63:0] TH = `STEP_THRESHOLD;

  logic        CLK;
  logic        resetn;
  logic        word_valid;
  logic        word_ready;
  logic [63:0] word_data;
  logic        reply_valid;
  logic        reply_ready;
  logic [63:0] reply_data;
  logic        halt_n;
  logic        step;
  logic        dir;
  logic        enable;
  logic        busy;
  logic        move_done;
  logic        buffer_ready;

  move_t              exp_q[$];   // Moves sent, oldest first
  logic signed [63:0] model_acc;
  int cur_div;
  int cur_busy;
  int cur_steps;
  int done_count;
  int sent_count;
  int dropped;
  int errors;
  int checks;
  int tests;
  int budget;                     // Expected move cycles so far
  int longest_stall;              // Most cycles one word waited

  motion_top i_motion_top (.*);

  bind motion_top motion_props i_motion_props (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic check(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERR %0t: %s", $time, what);
    end
  endtask

  task automatic test_done(input string name);
    tests++;
    $display("test %s finished, errors so far %0d", name, errors);
  endtask

  // Threshold crossings over a number of ticks
  function automatic int run_model(input move_t m, input int ticks);
    logic signed [63:0] inc;
    int n;
    inc = m.increment;
    n = 0;
    for (int i = 0; i < ticks; i++) begin
      model_acc = model_acc + inc;
      inc = inc + m.incinc;
      if (model_acc > TH) begin
        model_acc = model_acc - TH;
        n++;
      end
    end
    return n;
  endfunction

  // Starts and ends at a falling edge
  task automatic send_word(input logic [63:0] w);
    bit taken;
    int waited;
    word_valid = 1'b1;
    word_data  = w;
    waited = 0;
    taken = word_ready;
    while (!taken) begin
      waited++;
      @(negedge CLK);
      taken = word_ready;
    end
    if (waited > longest_stall) longest_stall = waited;
    @(negedge CLK);
    word_valid = 1'b0;
  endtask

  task automatic send_move(input bit d, input int dur, input logic signed [63:0] inc,
                           input logic signed [63:0] incinc);
    move_t m;
    m.dir       = d;
    m.duration  = 64'(dur);
    m.increment = inc;
    m.incinc    = incinc;
    exp_q.push_back(m);
    budget += dur * (cur_div + 1);
    sent_count++;
    send_word({`CMD_COORDINATED_STEP, 55'd0, d});
    send_word(64'(dur));
    send_word(inc);
    send_word(incinc);
  endtask

  task automatic send_random_move();
    logic signed [63:0] frac;
    int k;
    frac = 64'($urandom % 769);
    k = int'($urandom % 3);
    send_move(1'($urandom % 2), 1 + int'($urandom % 6), (TH * frac) >>> 8,
              64'(k - 1) * (TH >>> 4));
  endtask

  task automatic set_div(input int d);
    send_word({`CMD_CLK_DIVISOR, 48'd0, 8'(d)});
    cur_div = d;
  endtask

  task automatic set_enable(input bit e);
    send_word({`CMD_MOTOR_ENABLE, 55'd0, e});
  endtask

  task automatic wait_idle();
    while (exp_q.size() > 0 || busy) @(negedge CLK);
    repeat (2) @(negedge CLK);
  endtask

  // Checks each move against the model at move_done
  initial begin : monitor
    bit    prev_busy;
    move_t m;
    int    want;
    prev_busy = 1'b0;
    forever begin
      @(negedge CLK);
      if (busy && !prev_busy) begin
        cur_busy  = 0;
        cur_steps = 0;
      end
      if (busy) begin
        cur_busy++;
        if (exp_q.size() > 0) check(dir == exp_q[0].dir, "dir differs from the move");
      end
      if (step) cur_steps++;
      if (move_done) begin
        if (exp_q.size() == 0) begin
          check(1'b0, "move_done with no move pending");
        end else begin
          m = exp_q.pop_front();
          want = run_model(m, int'(m.duration));
          check(cur_busy == int'(m.duration) * (cur_div + 1),
                $sformatf("move length %0d, expected %0d", cur_busy,
                          int'(m.duration) * (cur_div + 1)));
          check(cur_steps == want,
                $sformatf("step count %0d, expected %0d", cur_steps, want));
          done_count++;
        end
      end
      prev_busy = busy;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget + 2000) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  end

  task automatic version_test();
    int got;
    got = 0;
    send_word({`CMD_API_VERSION, 56'd0});
    for (int i = 0; i < 40; i++) begin
      if (i < 4) begin
        reply_ready = 1'b0;              // Reply waits a few cycles first
      end else begin
        reply_ready = 1'($urandom % 2);  // Random stalls
      end
      if (reply_valid && reply_ready) begin
        got++;
        check(reply_data[63:24] == 40'd0 && reply_data[23:16] == `VERSION_MAJOR
              && reply_data[15:8] == `VERSION_MINOR && reply_data[7:0] == `VERSION_PATCH,
              $sformatf("reply %h, expected version %0d.%0d.%0d", reply_data,
                        `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH));
      end
      @(negedge CLK);
    end
    reply_ready = 1'b0;
    check(got == 1, $sformatf("%0d replies to one version query", got));
  endtask

  task automatic halt_test();
    move_t m;
    int want;
    set_div(1);
    set_enable(1'b0);                // Queue all three before the first starts
    for (int i = 0; i < 3; i++) send_move(1'b1, 6, TH >>> 1, 64'sd0);
    set_enable(1'b1);
    while (!busy) @(negedge CLK);
    repeat (4) @(negedge CLK);
    halt_n = 1'b0;                   // Fifth busy cycle
    @(negedge CLK);
    check(!busy, "busy still high one edge after halt");
    halt_n = 1'b1;
    m = exp_q.pop_front();
    want = run_model(m, 4 / (cur_div + 1));
    check(cur_steps == want, $sformatf("halted move made %0d steps, expected %0d",
                                       cur_steps, want));
    dropped += 1 + exp_q.size();
    exp_q.delete();
    for (int i = 0; i < 40; i++) begin
      check(!move_done && !busy, "activity after halt with no new move");
      @(negedge CLK);
    end
    send_random_move();
    send_random_move();
    wait_idle();
    check(done_count == sent_count - dropped, "move_done count after halt");
  endtask

  initial begin
    resetn      = 1'b0;
    word_valid  = 1'b0;
    word_data   = '0;
    reply_ready = 1'b0;
    halt_n      = 1'b1;
    model_acc   = '0;
    cur_div     = 3;
    void'($urandom(32'h53d7_8c85));

    repeat (10) @(negedge CLK);
    check(!step && !move_done && !busy && !reply_valid && !enable, "outputs during reset");
    resetn = 1'b1;
    @(negedge CLK);
    check(word_ready && buffer_ready && !busy && !enable, "outputs after reset");
    test_done("reset");

    version_test();
    version_test();
    test_done("version");

    set_enable(1'b1);
    for (int r = 0; r < 4; r++) begin
      set_div(int'($urandom % 4));
      for (int i = 0; i < 3; i++) send_random_move();
      wait_idle();
    end
    check(done_count == sent_count, "move_done count in random moves");
    test_done("random_moves");

    // Fill the move buffer with the motor off
    set_div(3);
    set_enable(1'b0);
    for (int i = 0; i < `MOVE_BUFFER_DEPTH; i++) send_move(1'(i), 6, TH, 64'sd0);
    repeat (3) @(negedge CLK);
    check(!buffer_ready, "buffer_ready high with a full buffer");
    check(!busy, "move started while disabled");
    set_enable(1'b1);
    longest_stall = 0;
    for (int i = 0; i < 3; i++) send_move(1'(i), 6, TH + (TH >>> 2), 64'sd0);
    // A push into a free slot stalls the next word for one cycle only
    check(longest_stall > 1, "word_ready never stayed low on a full buffer");
    wait_idle();
    check(done_count == sent_count, "move_done count after back-pressure");
    test_done("back_pressure");

    halt_test();
    test_done("halt");

    errors += i_motion_top.i_motion_props.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/stepper_pkg.sv
src/sync_fifo.sv
src/tick_divider.sv
src/cmd_decoder.sv
src/dda_stepper.sv
src/motion_top.sv
verif/motion_props.sv
verif/motion_tb.sv
